// File: decode_pkg.sv
// shared register, segment and displacement codes for the 32-bit address mode decoder
`default_nettype none

package decode_pkg;

    // general registers, numbered as in the modrm and sib fields
    typedef enum logic [2:0] {
        eax = 3'd0,
        ecx = 3'd1,
        edx = 3'd2,
        ebx = 3'd3,
        esp = 3'd4,
        ebp = 3'd5,
        esi = 3'd6,
        edi = 3'd7
    } gpr_e;

    // default segment for the effective address
    typedef enum logic [0:0] {
        seg_ds = 1'b0,
        seg_ss = 1'b1
    } seg_e;

    // number of displacement bytes after modrm/sib
    typedef enum logic [1:0] {
        disp_0  = 2'd0,
        disp_8  = 2'd1,
        disp_32 = 2'd2
    } disp_len_e;

    // rm value that pulls in a sib byte
    localparam logic [2:0] rm_sib = 3'b100;
    // under mod 00, no base and a 32-bit displacement
    localparam logic [2:0] rm_disp_only = 3'b101;
    // sib index value meaning no index register
    localparam logic [2:0] index_none = 3'b100;
    // register form
    localparam logic [1:0] mod_reg = 2'b11;

endpackage

`default_nettype wire

// File: decode_stage_2.sv
// modrm decoder, splits the byte and derives sib need, base use and displacement length
`timescale 1ns/1ps
`default_nettype none

module decode_stage_2 (
    input  logic [7:0]            modrm,
    output logic [1:0]            mod,
    output logic [2:0]            reg_opcode,
    output decode_pkg::gpr_e      rm,
    output logic                  reg_form,
    output logic                  sib_present,
    output logic                  modrm_base_used,
    output decode_pkg::disp_len_e modrm_disp_len
);
    import decode_pkg::*;

    // mod 00 with rm 101 carries only a disp32
    logic disp_only;

    // raw field split
    assign mod        = modrm[7:6];
    assign reg_opcode = modrm[5:3];
    assign rm         = gpr_e'(modrm[2:0]);

    assign reg_form  = (mod == mod_reg);
    assign disp_only = (mod == 2'b00) && (modrm[2:0] == rm_disp_only);

    // sib only exists for memory forms
    assign sib_present     = !reg_form && (modrm[2:0] == rm_sib);
    assign modrm_base_used = !disp_only;

    // length follows mod, disp_only is the odd one
    always_comb begin
        case (mod)
            2'b00: begin
                if (disp_only) begin
                    modrm_disp_len = disp_32;
                end else begin
                    modrm_disp_len = disp_0;
                end
            end
            2'b01: begin
                modrm_disp_len = disp_8;
            end
            2'b10: begin
                modrm_disp_len = disp_32;
            end
            default: begin
                // register form
                modrm_disp_len = disp_0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode_stage_3.sv
// sib decoder for scale, index, base and undefined effective address
`timescale 1ns/1ps
`default_nettype none

module decode_stage_3 (
    input  logic [7:0]            sib,
    input  logic [1:0]            mod,
    output logic [1:0]            scale_factor,
    output logic                  index_reg_used,
    output decode_pkg::gpr_e      index_reg_index,
    output logic                  base_reg_used,
    output decode_pkg::gpr_e      base_reg_index,
    output decode_pkg::disp_len_e sib_disp_len,
    output logic                  effective_address_undefined
);
    import decode_pkg::*;

    // base 101 under mod 00 means no base, disp32 instead
    logic no_base;
    logic index_is_none;

    // ss / index / base fields
    assign scale_factor    = sib[7:6];
    assign index_reg_index = gpr_e'(sib[5:3]);
    assign base_reg_index  = gpr_e'(sib[2:0]);

    assign index_is_none  = (sib[5:3] == index_none);
    assign no_base        = (mod == 2'b00) && (sib[2:0] == rm_disp_only);
    assign index_reg_used = !index_is_none;
    assign base_reg_used  = !no_base;

    // no index needs ss 00, otherwise the address is undefined
    assign effective_address_undefined = index_is_none && (scale_factor != 2'b00);

    // same mod rule as modrm, plus the no-base case
    always_comb begin
        case (mod)
            2'b00: begin
                if (no_base) begin
                    sib_disp_len = disp_32;
                end else begin
                    sib_disp_len = disp_0;
                end
            end
            2'b01: begin
                sib_disp_len = disp_8;
            end
            2'b10: begin
                sib_disp_len = disp_32;
            end
            default: begin
                sib_disp_len = disp_0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: displacement_collector.sv
// gathers little-endian displacement bytes and sign-extends the 8-bit form
`timescale 1ns/1ps
`default_nettype none

module displacement_collector (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_start,
    input  decode_pkg::disp_len_e disp_len,
    input  logic                  disp_byte_valid,
    input  logic [7:0]            byte_in,
    output logic                  disp_last,
    output logic [31:0]           displacement
);
    import decode_pkg::*;

    // bytes still expected
    logic [2:0]  remaining;
    // next lane to fill, lowest first
    logic [1:0]  lane;
    // 8-bit displacement, sign-extend on output
    logic        short_form;
    logic [31:0] acc;
    // accumulator with the byte now arriving merged in
    logic [31:0] acc_next;

    always_comb begin
        acc_next = acc;
        if (disp_byte_valid) begin
            acc_next[{lane, 3'b000} +: 8] = byte_in;
        end
    end

    assign disp_last = disp_byte_valid && (remaining == 3'd1);

    // includes the final byte, so it is sampled on the edge ending disp_last
    assign displacement = short_form ? {{24{acc_next[7]}}, acc_next[7:0]} : acc_next;

    // byte count and lane pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining  <= 3'd0;
            lane       <= 2'd0;
            short_form <= 1'b0;
        end else if (disp_start) begin
            remaining  <= (disp_len == disp_8) ? 3'd1 : 3'd4;
            lane       <= 2'd0;
            short_form <= (disp_len == disp_8);
        end else if (disp_byte_valid && (remaining != 3'd0)) begin
            remaining <= remaining - 3'd1;
            lane      <= lane + 2'd1;
        end
    end

    // accumulator
    always_ff @(posedge clk) begin
        if (disp_start) begin
            acc <= 32'd0;
        end else if (disp_byte_valid) begin
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: addr_mode_sequencer.sv
// state machine stepping through modrm, sib and displacement bytes, holds the decoded form
`timescale 1ns/1ps
`default_nettype none

module addr_mode_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            byte_in,
    input  logic                  byte_valid,
    // to / from the decoders
    output logic [7:0]            modrm_q,
    output logic [7:0]            sib_q,
    input  logic [2:0]            reg_opcode,
    input  decode_pkg::gpr_e      rm,
    input  logic                  reg_form,
    input  logic                  sib_present,
    input  logic                  modrm_base_used,
    input  decode_pkg::disp_len_e modrm_disp_len,
    input  logic [1:0]            scale_factor,
    input  logic                  index_reg_used,
    input  decode_pkg::gpr_e      index_reg_index,
    input  logic                  base_reg_used,
    input  decode_pkg::gpr_e      base_reg_index,
    input  decode_pkg::disp_len_e sib_disp_len,
    input  logic                  effective_address_undefined,
    // to / from the collector
    output logic                  disp_start,
    output decode_pkg::disp_len_e disp_len,
    output logic                  disp_byte_valid,
    input  logic                  disp_last,
    input  logic [31:0]           displacement,
    // decoded form
    output logic                  decode_done,
    output logic                  reg_form_o,
    output logic [2:0]            reg_opcode_o,
    output logic                  base_used_o,
    output decode_pkg::gpr_e      base_reg_o,
    output logic                  index_used_o,
    output decode_pkg::gpr_e      index_reg_o,
    output logic [1:0]            scale_o,
    output decode_pkg::seg_e      segment_o,
    output decode_pkg::disp_len_e disp_len_o,
    output logic [31:0]           displacement_o,
    output logic                  ea_undefined_o
);
    import decode_pkg::*;

    typedef enum logic [1:0] {
        st_modrm = 2'd0,
        st_sib   = 2'd1,
        st_disp  = 2'd2
    } state_e;

    state_e      state;
    logic [7:0]  modrm_r;
    logic [7:0]  sib_r;
    logic        modrm_take;
    logic        sib_take;
    logic        disp_take;
    logic        finish;
    // fields of the form in flight
    logic        sel_base_used;
    gpr_e        sel_base;
    logic        sel_index_used;
    gpr_e        sel_index;
    logic [1:0]  sel_scale;
    disp_len_e   sel_disp_len;
    logic        sel_undef;
    seg_e        sel_segment;

    assign modrm_take = (state == st_modrm) && byte_valid;
    assign sib_take   = (state == st_sib) && byte_valid;
    assign disp_take  = (state == st_disp) && byte_valid;

    // bypass so the decoders see a byte in its own strobe cycle
    assign modrm_q = modrm_take ? byte_in : modrm_r;
    assign sib_q   = sib_take ? byte_in : sib_r;

    // sib fields win when present, index and scale zero without it
    assign sel_base_used  = sib_present ? base_reg_used : modrm_base_used;
    assign sel_base       = sib_present ? base_reg_index : rm;
    assign sel_index_used = sib_present && index_reg_used;
    assign sel_index      = sib_present ? index_reg_index : eax;
    assign sel_scale      = sib_present ? scale_factor : 2'b00;
    assign sel_disp_len   = sib_present ? sib_disp_len : modrm_disp_len;
    assign sel_undef      = sib_present && effective_address_undefined;

    // stack segment for esp/ebp based addressing
    assign sel_segment = (sel_base_used && ((sel_base == esp) || (sel_base == ebp))) ?
                         seg_ss : seg_ds;

    // form ends on this byte?
    assign finish = (modrm_take && (reg_form || (!sib_present && modrm_disp_len == disp_0)))
                 || (sib_take && (sib_disp_len == disp_0))
                 || (disp_take && disp_last);

    // displacement follows modrm or sib
    assign disp_start = (modrm_take && !reg_form && !sib_present && modrm_disp_len != disp_0)
                     || (sib_take && (sib_disp_len != disp_0));
    assign disp_len        = sel_disp_len;
    assign disp_byte_valid = disp_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_modrm;
        end else begin
            case (state)
                st_modrm: begin
                    if (modrm_take && !reg_form) begin
                        if (sib_present) begin
                            state <= st_sib;
                        end else if (disp_start) begin
                            state <= st_disp;
                        end
                    end
                end
                st_sib: begin
                    if (sib_take) begin
                        state <= disp_start ? st_disp : st_modrm;
                    end
                end
                st_disp: begin
                    if (disp_take && disp_last) begin
                        state <= st_modrm;
                    end
                end
                default: begin
                    state <= st_modrm;
                end
            endcase
        end
    end

    // instruction bytes, held while the rest of the form arrives
    always_ff @(posedge clk) begin
        if (modrm_take) begin
            modrm_r <= byte_in;
        end
        if (sib_take) begin
            sib_r <= byte_in;
        end
    end

    // result registers, loaded with the done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            decode_done    <= 1'b0;
            reg_form_o     <= 1'b0;
            reg_opcode_o   <= 3'd0;
            base_used_o    <= 1'b0;
            base_reg_o     <= eax;
            index_used_o   <= 1'b0;
            index_reg_o    <= eax;
            scale_o        <= 2'b00;
            segment_o      <= seg_ds;
            disp_len_o     <= disp_0;
            displacement_o <= 32'd0;
            ea_undefined_o <= 1'b0;
        end else begin
            decode_done <= finish;
            if (finish) begin
                reg_form_o   <= reg_form;
                reg_opcode_o <= reg_opcode;
                if (reg_form) begin
                    // no memory operand at all
                    base_used_o    <= 1'b0;
                    base_reg_o     <= eax;
                    index_used_o   <= 1'b0;
                    index_reg_o    <= eax;
                    scale_o        <= 2'b00;
                    segment_o      <= seg_ds;
                    disp_len_o     <= disp_0;
                    ea_undefined_o <= 1'b0;
                end else begin
                    base_used_o    <= sel_base_used;
                    base_reg_o     <= sel_base;
                    index_used_o   <= sel_index_used;
                    index_reg_o    <= sel_index;
                    scale_o        <= sel_scale;
                    segment_o      <= sel_segment;
                    disp_len_o     <= sel_disp_len;
                    ea_undefined_o <= sel_undef;
                end
                // zero unless the form ended on a displacement byte
                displacement_o <= disp_take ? displacement : 32'd0;
            end
        end
    end

endmodule

`default_nettype wire

// File: addr_mode_top.sv
// top level of the 32-bit address mode decoder, connects decoders, collector and sequencer
`timescale 1ns/1ps
`default_nettype none

module addr_mode_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            byte_in,
    input  logic                  byte_valid,
    output logic                  decode_done,
    output logic                  reg_form_o,
    output logic [2:0]            reg_opcode_o,
    output logic                  base_used_o,
    output decode_pkg::gpr_e      base_reg_o,
    output logic                  index_used_o,
    output decode_pkg::gpr_e      index_reg_o,
    output logic [1:0]            scale_o,
    output decode_pkg::seg_e      segment_o,
    output decode_pkg::disp_len_e disp_len_o,
    output logic [31:0]           displacement_o,
    output logic                  ea_undefined_o
);
    import decode_pkg::*;

    // modrm path
    logic [7:0]  modrm_q;
    logic [1:0]  mod;
    logic [2:0]  reg_opcode;
    gpr_e        rm;
    logic        reg_form;
    logic        sib_present;
    logic        modrm_base_used;
    disp_len_e   modrm_disp_len;
    // sib path
    logic [7:0]  sib_q;
    logic [1:0]  scale_factor;
    logic        index_reg_used;
    gpr_e        index_reg_index;
    logic        base_reg_used;
    gpr_e        base_reg_index;
    disp_len_e   sib_disp_len;
    logic        effective_address_undefined;
    // displacement path
    logic        disp_start;
    disp_len_e   disp_len;
    logic        disp_byte_valid;
    logic        disp_last;
    logic [31:0] displacement;

    decode_stage_2 u_stage_2 (
        .modrm           (modrm_q),
        .mod             (mod),
        .reg_opcode      (reg_opcode),
        .rm              (rm),
        .reg_form        (reg_form),
        .sib_present     (sib_present),
        .modrm_base_used (modrm_base_used),
        .modrm_disp_len  (modrm_disp_len)
    );

    // mod comes straight from the held modrm byte
    decode_stage_3 u_stage_3 (
        .sib                         (sib_q),
        .mod                         (mod),
        .scale_factor                (scale_factor),
        .index_reg_used              (index_reg_used),
        .index_reg_index             (index_reg_index),
        .base_reg_used               (base_reg_used),
        .base_reg_index              (base_reg_index),
        .sib_disp_len                (sib_disp_len),
        .effective_address_undefined (effective_address_undefined)
    );

    displacement_collector u_collector (
        .clk             (clk),
        .rst             (rst),
        .disp_start      (disp_start),
        .disp_len        (disp_len),
        .disp_byte_valid (disp_byte_valid),
        .byte_in         (byte_in),
        .disp_last       (disp_last),
        .displacement    (displacement)
    );

    addr_mode_sequencer u_sequencer (
        .clk                         (clk),
        .rst                         (rst),
        .byte_in                     (byte_in),
        .byte_valid                  (byte_valid),
        .modrm_q                     (modrm_q),
        .sib_q                       (sib_q),
        .reg_opcode                  (reg_opcode),
        .rm                          (rm),
        .reg_form                    (reg_form),
        .sib_present                 (sib_present),
        .modrm_base_used             (modrm_base_used),
        .modrm_disp_len              (modrm_disp_len),
        .scale_factor                (scale_factor),
        .index_reg_used              (index_reg_used),
        .index_reg_index             (index_reg_index),
        .base_reg_used               (base_reg_used),
        .base_reg_index              (base_reg_index),
        .sib_disp_len                (sib_disp_len),
        .effective_address_undefined (effective_address_undefined),
        .disp_start                  (disp_start),
        .disp_len                    (disp_len),
        .disp_byte_valid             (disp_byte_valid),
        .disp_last                   (disp_last),
        .displacement                (displacement),
        .decode_done                 (decode_done),
        .reg_form_o                  (reg_form_o),
        .reg_opcode_o                (reg_opcode_o),
        .base_used_o                 (base_used_o),
        .base_reg_o                  (base_reg_o),
        .index_used_o                (index_used_o),
        .index_reg_o                 (index_reg_o),
        .scale_o                     (scale_o),
        .segment_o                   (segment_o),
        .disp_len_o                  (disp_len_o),
        .displacement_o              (displacement_o),
        .ea_undefined_o              (ea_undefined_o)
    );

endmodule

`default_nettype wire

// File: tb_addr_mode.sv
// address mode decoder testbench that replays a byte trace and checks every decoded field
`timescale 1ns/1ps
`default_nettype none

module tb_addr_mode;

    localparam int max_forms = 64;
    localparam int num_fields = 11;

    logic        clk;
    logic        rst;
    logic [7:0]  byte_in;
    logic        byte_valid;
    logic        decode_done;
    logic        reg_form_o;
    logic [2:0]  reg_opcode_o;
    logic        base_used_o;
    logic [2:0]  base_reg_o;
    logic        index_used_o;
    logic [2:0]  index_reg_o;
    logic [1:0]  scale_o;
    logic        segment_o;
    logic [1:0]  disp_len_o;
    logic [31:0] displacement_o;
    logic        ea_undefined_o;

    // one trace entry per addressing form
    int              num_forms;
    logic [8*32-1:0] test_name [0:max_forms-1];
    int              gap_en [0:max_forms-1];
    int              num_bytes [0:max_forms-1];
    logic [7:0]      form_bytes [0:max_forms-1][0:5];
    logic [31:0]     exp_field [0:max_forms-1][0:num_fields-1];
    string           field_names [0:num_fields-1] = '{"reg_form", "reg_opcode", "base_used",
        "base_reg", "index_used", "index_reg", "scale", "segment", "disp_len", "displacement",
        "ea_undefined"};

    // byte slots in drive order with the strobe in bit 8
    logic [8:0]      slot_data [$];
    // form that ends in each slot or -1
    int              slot_form [$];
    int              total_bytes;
    integer          seed;
    int              cycle_count;
    int              timeout_limit;
    // form waiting for its done pulse
    int              pending;
    int              pending_cycle;
    // form now on the outputs
    int              held;

    addr_mode_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .byte_in        (byte_in),
        .byte_valid     (byte_valid),
        .decode_done    (decode_done),
        .reg_form_o     (reg_form_o),
        .reg_opcode_o   (reg_opcode_o),
        .base_used_o    (base_used_o),
        .base_reg_o     (base_reg_o),
        .index_used_o   (index_used_o),
        .index_reg_o    (index_reg_o),
        .scale_o        (scale_o),
        .segment_o      (segment_o),
        .disp_len_o     (disp_len_o),
        .displacement_o (displacement_o),
        .ea_undefined_o (ea_undefined_o)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic read_trace();
        int fd;
        int code;
        logic [8*256-1:0] line;
        num_forms = 0;
        fd = $fopen("addr_mode_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file addr_mode_trace.txt");
            abort_run();
        end else begin
            while (!$feof(fd) && num_forms < max_forms) begin
                line = '0;
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line,
                        "%s %d %d %h %h %h %h %h %h %d %d %d %d %d %d %d %d %d %h %d",
                        test_name[num_forms], gap_en[num_forms], num_bytes[num_forms],
                        form_bytes[num_forms][0], form_bytes[num_forms][1],
                        form_bytes[num_forms][2], form_bytes[num_forms][3],
                        form_bytes[num_forms][4], form_bytes[num_forms][5],
                        exp_field[num_forms][0], exp_field[num_forms][1],
                        exp_field[num_forms][2], exp_field[num_forms][3],
                        exp_field[num_forms][4], exp_field[num_forms][5],
                        exp_field[num_forms][6], exp_field[num_forms][7],
                        exp_field[num_forms][8], exp_field[num_forms][9],
                        exp_field[num_forms][10]);
                    // comment and blank lines never scan all columns
                    if (code == 20) begin
                        num_forms++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // 0 to 3 idle cycles before each byte unless the form runs back to back
    task automatic build_stream();
        int f;
        int k;
        int g;
        int gap;
        total_bytes = 0;
        for (f = 0; f < num_forms; f++) begin
            for (k = 0; k < num_bytes[f]; k++) begin
                gap = 0;
                if (gap_en[f] != 0) begin
                    gap = $random(seed) & 3;
                end
                for (g = 0; g < gap; g++) begin
                    slot_data.push_back(9'h000);
                    slot_form.push_back(-1);
                end
                slot_data.push_back({1'b1, form_bytes[f][k]});
                slot_form.push_back((k == num_bytes[f] - 1) ? f : -1);
                total_bytes++;
            end
        end
    endtask

    task automatic check_fields(input int f);
        logic [31:0] act [0:num_fields-1];
        int k;
        act[0]  = 32'(reg_form_o);
        act[1]  = 32'(reg_opcode_o);
        act[2]  = 32'(base_used_o);
        act[3]  = 32'(base_reg_o);
        act[4]  = 32'(index_used_o);
        act[5]  = 32'(index_reg_o);
        act[6]  = 32'(scale_o);
        act[7]  = 32'(segment_o);
        act[8]  = 32'(disp_len_o);
        act[9]  = displacement_o;
        act[10] = 32'(ea_undefined_o);
        for (k = 0; k < num_fields; k++) begin
            assert (act[k] == exp_field[f][k]) else begin
                $display("FAIL %0s %0s expected %h actual %h",
                         test_name[f], field_names[k], exp_field[f][k], act[k]);
                abort_run();
            end
        end
    endtask

    // outputs move on the rising edge and are settled by the falling edge
    task automatic observe_outputs();
        if (decode_done) begin
            if (pending < 0) begin
                $display("decode_done came before the last byte of a form");
                abort_run();
            end else begin
                check_fields(pending);
                held = pending;
                pending = -1;
            end
        end else begin
            if (pending >= 0 && cycle_count > pending_cycle + 2) begin
                $display("decode_done missing 2 cycles after the last byte of %0s",
                         test_name[pending]);
                abort_run();
            end
            // fields hold between done pulses
            if (held >= 0) begin
                check_fields(held);
            end
        end
    endtask

    initial begin
        int i;
        seed = 78;
        pending = -1;
        pending_cycle = 0;
        held = -1;
        cycle_count = 0;
        timeout_limit = 0;
        clk = 1'b0;
        rst = 1'b1;
        byte_in = 8'h00;
        byte_valid = 1'b0;
        read_trace();
        if (num_forms == 0) begin
            $display("the trace file holds no addressing forms");
            abort_run();
        end
        build_stream();
        timeout_limit = total_bytes * 5 + 20;
        // two rising edges in reset
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < slot_data.size() + 3; i++) begin
            @(negedge clk);
            observe_outputs();
            if (i < slot_data.size()) begin
                if (slot_form[i] >= 0 && pending >= 0) begin
                    $display("decode_done missing for %0s when the next form ended",
                             test_name[pending]);
                    abort_run();
                end
                byte_valid = slot_data[i][8];
                byte_in = slot_data[i][7:0];
                if (slot_form[i] >= 0) begin
                    pending = slot_form[i];
                    pending_cycle = cycle_count;
                end
            end else begin
                byte_valid = 1'b0;
                byte_in = 8'h00;
            end
        end
        $display("Done: no errors");
        $finish;
    end

    // run limit scales with the trace length
    initial begin
        wait (timeout_limit != 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
        end
        $display("timeout, the run went past %0d cycles", timeout_limit);
        abort_run();
    end

endmodule

`default_nettype wire

// File: addr_mode_trace.txt
# name gap nbytes b0 b1 b2 b3 b4 b5 reg_form reg_op base_used base index_used index scale seg disp_len disp ea_undef
# gap 1 = random idle cycles, bytes in hex with unused columns 00, seg 0 ds 1 ss, disp_len 0 none 1 8bit 2 32bit, disp in hex
reg_c0        1 1 c0 00 00 00 00 00 1 0 0 0 0 0 0 0 0 00000000 0
reg_fb        1 1 fb 00 00 00 00 00 1 7 0 0 0 0 0 0 0 00000000 0
m00_eax       1 1 00 00 00 00 00 00 0 0 1 0 0 0 0 0 0 00000000 0
m00_ecx       1 1 09 00 00 00 00 00 0 1 1 1 0 0 0 0 0 00000000 0
m00_edx       1 1 12 00 00 00 00 00 0 2 1 2 0 0 0 0 0 00000000 0
m00_ebx       1 1 1b 00 00 00 00 00 0 3 1 3 0 0 0 0 0 00000000 0
m00_disp32    1 5 2d 78 56 34 12 00 0 5 0 5 0 0 0 0 2 12345678 0
m00_esi       1 1 36 00 00 00 00 00 0 6 1 6 0 0 0 0 0 00000000 0
m00_edi       1 1 3f 00 00 00 00 00 0 7 1 7 0 0 0 0 0 00000000 0
m01_eax_pos   1 2 40 7f 00 00 00 00 0 0 1 0 0 0 0 0 1 0000007f 0
m01_ecx       1 2 49 10 00 00 00 00 0 1 1 1 0 0 0 0 1 00000010 0
m01_edx       1 2 52 fe 00 00 00 00 0 2 1 2 0 0 0 0 1 fffffffe 0
m01_ebx       1 2 5b 81 00 00 00 00 0 3 1 3 0 0 0 0 1 ffffff81 0
m01_ebp_neg   1 2 45 80 00 00 00 00 0 0 1 5 0 0 0 1 1 ffffff80 0
m01_esi       1 2 76 00 00 00 00 00 0 6 1 6 0 0 0 0 1 00000000 0
m01_edi       1 2 7f 01 00 00 00 00 0 7 1 7 0 0 0 0 1 00000001 0
m10_eax       1 5 80 ff ff ff ff 00 0 0 1 0 0 0 0 0 2 ffffffff 0
m10_ecx       1 5 89 00 00 00 00 00 0 1 1 1 0 0 0 0 2 00000000 0
m10_edx       1 5 92 78 56 34 12 00 0 2 1 2 0 0 0 0 2 12345678 0
m10_ebx       1 5 9b 00 00 00 80 00 0 3 1 3 0 0 0 0 2 80000000 0
m10_ebp       1 5 95 01 02 03 04 00 0 2 1 5 0 0 0 1 2 04030201 0
m10_esi       1 5 b6 04 03 02 01 00 0 6 1 6 0 0 0 0 2 01020304 0
m10_edi       1 5 bf ef be ad de 00 0 7 1 7 0 0 0 0 2 deadbeef 0
sib_scale2    1 2 04 88 00 00 00 00 0 0 1 0 1 1 2 0 0 00000000 0
sib_esp       1 2 0c 24 00 00 00 00 0 1 1 4 0 4 0 1 0 00000000 0
sib_esp_d32   1 6 84 24 00 01 00 00 0 0 1 4 0 4 0 1 2 00000100 0
sib_nobase    1 6 14 c5 78 56 34 12 0 2 0 5 1 0 3 0 2 12345678 0
sib_ebp_d8    1 3 5c 6d 80 00 00 00 0 3 1 5 1 5 1 1 1 ffffff80 0
sib_d32       1 6 a4 f7 11 22 33 44 0 4 1 7 1 6 3 0 2 44332211 0
sib_undef     1 2 04 60 00 00 00 00 0 0 1 0 0 4 1 0 0 00000000 1
sib_undef_d8  1 3 44 e1 7f 00 00 00 0 0 1 1 0 4 3 0 1 0000007f 1
sib_noidx     1 2 04 23 00 00 00 00 0 0 1 3 0 4 0 0 0 00000000 0
b2b_reg       0 1 c9 00 00 00 00 00 1 1 0 0 0 0 0 0 0 00000000 0
b2b_m8        0 2 43 05 00 00 00 00 0 0 1 3 0 0 0 0 1 00000005 0
b2b_reg2      0 1 d2 00 00 00 00 00 1 2 0 0 0 0 0 0 0 00000000 0
b2b_sib       0 6 34 1d 00 10 00 00 0 6 0 5 1 3 0 0 2 00001000 0
b2b_reg3      0 1 e7 00 00 00 00 00 1 4 0 0 0 0 0 0 0 00000000 0
b2b_m0        0 1 00 00 00 00 00 00 0 0 1 0 0 0 0 0 0 00000000 0

// File: compile.f
decode_pkg.sv
decode_stage_2.sv
decode_stage_3.sv
displacement_collector.sv
addr_mode_sequencer.sv
addr_mode_top.sv
tb_addr_mode.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_addr_mode
FILELIST  := compile.f
TRACE     := addr_mode_trace.txt
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TRACE)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
